// File: fibgen.f
hdl/fib_pkg.sv
hdl/bcd_amount_decoder.sv
hdl/fib_executor.sv
hdl/bcd_result_encoder.sv
hdl/fibgen.sv
testbench/tb_fibgen.sv

// File: hdl/bcd_amount_decoder.sv
`timescale 1ns/1ps

module bcd_amount_decoder
    (
        input   logic               i_clk,
        input   logic               i_rst,

        input   logic               i_in_req,
        input   fib_pkg::gen_amt_t  i_gen_amt,
        output  logic               o_in_ack,

        output  logic               o_job_req,
        output  fib_pkg::fib_job_t  o_job,
        input   logic               i_job_ack
    );

    import fib_pkg::*;

    typedef enum logic [1:0] { e_idle, e_convert, e_offer, e_release } t_state;

    t_state r_state;
    logic   r_in_ack;
    logic   [3:0] r_count;
    logic   w_accept;

    logic   [AMOUNT_DIGITS*4-1:0] r_bcd;
    logic   [AMOUNT_DIGITS*4-1:0] w_bcd_shift;
    logic   [AMOUNT_DIGITS*4-1:0] w_bcd_adj;
    logic   [AMOUNT_BITS-1:0]     r_bin;

    // new job only when idle and the last host handshake has closed
    assign w_accept = (r_state == e_idle) && i_in_req && !r_in_ack;

    // ##################################################
    // shift right and subtract 3
    // ##################################################

    always_comb
    begin
        w_bcd_shift = r_bcd >> 1;
        for (int d = 0; d < AMOUNT_DIGITS; d++)
        begin
            if (w_bcd_shift[d*4 +: 4] > 4'd7)
                w_bcd_adj[d*4 +: 4] = w_bcd_shift[d*4 +: 4] - 4'd3;
            else
                w_bcd_adj[d*4 +: 4] = w_bcd_shift[d*4 +: 4];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_bcd <= i_gen_amt;
            r_bin <= '0;
        end
        else if (r_state == e_convert)
        begin
            r_bcd <= w_bcd_adj;
            r_bin <= {r_bcd[0], r_bin[AMOUNT_BITS-1:1]};    // lsb of ones falls into bin
        end
    end

    // ##################################################
    // control
    // ##################################################

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state  <= e_idle;
            r_in_ack <= 1'b0;
            r_count  <= '0;
        end
        else
        begin
            // host side, independent of the job FSM
            if (w_accept)
                r_in_ack <= 1'b1;
            else if (!i_in_req)
                r_in_ack <= 1'b0;

            case (r_state)
                e_idle:
                begin
                    if (w_accept)
                    begin
                        r_count <= 4'(AMOUNT_DIGITS * 4);
                        r_state <= e_convert;
                    end
                end
                e_convert:
                begin
                    r_count <= r_count - 4'd1;
                    if (r_count == 4'd1)
                        r_state <= e_offer;
                end
                e_offer:    if (i_job_ack) r_state <= e_release;
                e_release:  if (!i_job_ack) r_state <= e_idle;    // wait for ack low
                default:    r_state <= e_idle;
            endcase
        end
    end

    assign o_in_ack  = r_in_ack;
    assign o_job_req = (r_state == e_offer);
    assign o_job     = '{index: r_bin};

endmodule

// File: hdl/bcd_result_encoder.sv
`timescale 1ns/1ps

module bcd_result_encoder
    (
        input   logic                   i_clk,
        input   logic                   i_rst,

        input   logic                   i_val_req,
        input   fib_pkg::fib_value_t    i_val,
        output  logic                   o_val_ack,

        output  logic                   o_out_req,
        output  fib_pkg::fib_result_t   o_result,
        input   logic                   i_out_ack
    );

    import fib_pkg::*;

    typedef enum logic [1:0] { e_idle, e_shift, e_offer, e_release } t_state;

    t_state r_state;
    logic   r_val_ack;
    logic   [3:0] r_count;
    logic   w_accept;

    logic   [VALUE_BITS-1:0]        r_bin;
    bcd_digit_t [RESULT_DIGITS-1:0] r_bcd;
    bcd_digit_t [RESULT_DIGITS-1:0] w_bcd_adj;
    logic   r_overflow;

    // only take a value once the host has closed the previous result
    assign w_accept = (r_state == e_idle) && i_val_req && !r_val_ack;

    // ##################################################
    // double dabble
    // ##################################################

    always_comb
    begin
        for (int d = 0; d < RESULT_DIGITS; d++)
        begin
            if (r_bcd[d] > 4'd4)
                w_bcd_adj[d] = r_bcd[d] + 4'd3;
            else
                w_bcd_adj[d] = r_bcd[d];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_bin      <= i_val.value;
            r_overflow <= i_val.overflow;
            if (i_val.overflow)
                r_bcd <= {RESULT_DIGITS{4'd9}};     // saturate
            else
                r_bcd <= '0;
        end
        else if (r_state == e_shift)
        begin
            {r_bcd, r_bin} <= {w_bcd_adj, r_bin} << 1;
        end
    end

    // ##################################################
    // control
    // ##################################################

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state   <= e_idle;
            r_val_ack <= 1'b0;
            r_count   <= '0;
        end
        else
        begin
            if (w_accept)
                r_val_ack <= 1'b1;
            else if (!i_val_req)
                r_val_ack <= 1'b0;

            case (r_state)
                e_idle:
                begin
                    if (w_accept)
                    begin
                        r_count <= 4'(VALUE_BITS);
                        r_state <= i_val.overflow ? e_offer : e_shift;
                    end
                end
                e_shift:
                begin
                    r_count <= r_count - 4'd1;
                    if (r_count == 4'd1)
                        r_state <= e_offer;
                end
                // result held until the host acks
                e_offer:    if (i_out_ack) r_state <= e_release;
                e_release:  if (!i_out_ack) r_state <= e_idle;
                default:    r_state <= e_idle;
            endcase
        end
    end

    assign o_val_ack = r_val_ack;
    assign o_out_req = (r_state == e_offer);
    assign o_result  = '{digits: r_bcd, overflow: r_overflow};

endmodule

// File: hdl/fib_executor.sv
`timescale 1ns/1ps

module fib_executor
    (
        input   logic               i_clk,
        input   logic               i_rst,

        input   logic               i_job_req,
        input   fib_pkg::fib_job_t  i_job,
        output  logic               o_job_ack,

        output  logic               o_val_req,
        output  fib_pkg::fib_value_t o_val,
        input   logic               i_val_ack
    );

    import fib_pkg::*;

    typedef enum logic [1:0] { e_idle, e_run, e_offer, e_release } t_state;

    t_state r_state;
    logic   r_job_ack;
    logic   [AMOUNT_BITS-1:0] r_index;     // counts down to 1
    logic   w_accept;
    logic   w_too_big;

    logic   [VALUE_BITS-1:0] r_cur, r_prev;
    logic   r_overflow;

    assign w_accept  = (r_state == e_idle) && i_job_req && !r_job_ack;
    assign w_too_big = (i_job.index > AMOUNT_BITS'(MAX_INDEX));

    // ##################################################
    // fibonacci datapath
    // ##################################################

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_cur      <= VALUE_BITS'(1);
            r_prev     <= '0;
            r_overflow <= w_too_big;
        end
        else if (r_state == e_run)
        begin
            if (r_index == '0)
                r_cur <= '0;                // fib(0)
            else if (r_index != AMOUNT_BITS'(1))
            begin
                r_cur  <= r_cur + r_prev;
                r_prev <= r_cur;
            end
        end
    end

    // ##################################################
    // control
    // ##################################################

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state   <= e_idle;
            r_job_ack <= 1'b0;
            r_index   <= '0;
        end
        else
        begin
            if (w_accept)
                r_job_ack <= 1'b1;
            else if (!i_job_req)
                r_job_ack <= 1'b0;

            case (r_state)
                e_idle:
                begin
                    if (w_accept)
                    begin
                        r_index <= i_job.index;
                        r_state <= w_too_big ? e_offer : e_run;    // overflow skips the sum
                    end
                end
                e_run:
                begin
                    if (r_index < AMOUNT_BITS'(2))
                        r_state <= e_offer;
                    else
                        r_index <= r_index - AMOUNT_BITS'(1);
                end
                e_offer:    if (i_val_ack) r_state <= e_release;
                e_release:  if (!i_val_ack) r_state <= e_idle;
                default:    r_state <= e_idle;
            endcase
        end
    end

    assign o_job_ack = r_job_ack;
    assign o_val_req = (r_state == e_offer);
    assign o_val     = '{value: r_cur, overflow: r_overflow};

endmodule

// File: hdl/fib_pkg.sv
package fib_pkg;

    // ##################################################
    // sizes
    // ##################################################

    localparam int AMOUNT_BITS   = 8;   // binary index from the decoder
    localparam int VALUE_BITS    = 14;  // binary fibonacci value
    localparam int MAX_INDEX     = 20;  // largest index that fits in four digits
    localparam int AMOUNT_DIGITS = 2;
    localparam int RESULT_DIGITS = 4;

    // ##################################################
    // payloads on the links
    // ##################################################

    typedef logic [3:0] bcd_digit_t;

    // host request
    typedef struct packed
    {
        bcd_digit_t tens;
        bcd_digit_t ones;
    } gen_amt_t;

    // decode -> execute
    typedef struct packed
    {
        logic [AMOUNT_BITS-1:0] index;
    } fib_job_t;

    // execute -> result
    typedef struct packed
    {
        logic [VALUE_BITS-1:0] value;
        logic                  overflow;
    } fib_value_t;

    // host response, digits[RESULT_DIGITS-1] is the most significant
    typedef struct packed
    {
        bcd_digit_t [RESULT_DIGITS-1:0] digits;
        logic                           overflow;
    } fib_result_t;

endpackage

// File: hdl/fibgen.sv
`timescale 1ns/1ps

module fibgen
    (
        input   logic                   i_clk,
        input   logic                   i_rst,

        // host request
        input   logic                   i_in_req,
        input   fib_pkg::gen_amt_t      i_gen_amt,
        output  logic                   o_in_ack,

        // host response
        output  logic                   o_out_req,
        output  fib_pkg::fib_result_t   o_result,
        input   logic                   i_out_ack
    );

    import fib_pkg::*;

    // ##################################################
    // stage links
    // ##################################################

    logic       dec_req, dec_ack;
    fib_job_t   dec_job;

    logic       exe_req, exe_ack;
    fib_value_t exe_value;

    // ##################################################
    // stages
    // ##################################################

    bcd_amount_decoder decoder_inst
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_in_req   (i_in_req),
        .i_gen_amt  (i_gen_amt),
        .o_in_ack   (o_in_ack),
        .o_job_req  (dec_req),
        .o_job      (dec_job),
        .i_job_ack  (dec_ack)
    );

    fib_executor executor_inst
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_job_req  (dec_req),
        .i_job      (dec_job),
        .o_job_ack  (dec_ack),
        .o_val_req  (exe_req),
        .o_val      (exe_value),
        .i_val_ack  (exe_ack)
    );

    bcd_result_encoder encoder_inst
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_val_req  (exe_req),
        .i_val      (exe_value),
        .o_val_ack  (exe_ack),
        .o_out_req  (o_out_req),
        .o_result   (o_result),
        .i_out_ack  (i_out_ack)
    );

endmodule

// File: testbench/tb_fibgen.sv
`timescale 1ns/1ps

module tb_fibgen;

    import fib_pkg::*;

    localparam int SEED           = 32'h7b75;
    localparam int N_JOBS         = 200;
    localparam int RESET_CYCLES   = 16;
    localparam int CYCLES_PER_JOB = 100;
    localparam int DRAIN_CYCLES   = 100;    // quiet time after the last result
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_JOBS * CYCLES_PER_JOB + DRAIN_CYCLES;
    localparam int MAX_IN_FLIGHT  = 3;      // one job per stage

    logic        i_clk;
    logic        i_rst;
    logic        i_in_req;
    gen_amt_t    i_gen_amt;
    logic        o_in_ack;
    logic        o_out_req;
    fib_result_t o_result;
    logic        i_out_ack;

    int          expected_q[$];             // amounts in request order
    int          results_checked;
    int          cycle_count;
    int          accepted_count;
    int          delivered_count;
    int          max_in_flight;
    logic        seen_req;
    logic        prev_in_req, prev_in_ack;
    logic        prev_out_req, prev_out_ack;
    fib_result_t prev_result;

    fibgen fibgen_inst
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_in_req   (i_in_req),
        .i_gen_amt  (i_gen_amt),
        .o_in_ack   (o_in_ack),
        .o_out_req  (o_out_req),
        .o_result   (o_result),
        .i_out_ack  (i_out_ack)
    );

    always #5 i_clk = ~i_clk;

    // ##################################################
    // reference model
    // ##################################################

    function automatic int fibonacci(input int n);
        int a;
        int b;
        int t;
        a = 0;
        b = 1;
        for (int i = 0; i < n; i++)
        begin
            t = a + b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    function automatic fib_result_t expected_result(input int amount);
        fib_result_t r;
        int          v;
        r.overflow = (amount > MAX_INDEX);
        v = r.overflow ? 9999 : fibonacci(amount);
        for (int d = 0; d < RESULT_DIGITS; d++)
        begin
            r.digits[d] = 4'(v % 10);   // digit 0 is the ones
            v = v / 10;
        end
        return r;
    endfunction

    function automatic gen_amt_t to_bcd(input int amount);
        gen_amt_t a;
        a.tens = 4'(amount / 10);
        a.ones = 4'(amount % 10);
        return a;
    endfunction

    // directed corners, a sweep of 3..19, then random with about a quarter overflowing
    function automatic int pick_amount(input int job);
        case (job)
            0:       return 0;
            1:       return 1;
            2:       return 2;
            3:       return 20;
            4:       return 21;
            default: ;
        endcase
        if (job < 22)
            return job - 2;
        if ($urandom_range(3) == 0)
            return int'($urandom_range(99, MAX_INDEX + 1));
        return int'($urandom_range(MAX_INDEX));
    endfunction

    // ##################################################
    // host side
    // ##################################################

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i_clk);
    endtask

    task automatic send_job(input int amount);
        wait_cycles($urandom_range(6));
        i_gen_amt <= to_bcd(amount);
        i_in_req  <= 1'b1;
        expected_q.push_back(amount);
        @(posedge i_clk);
        while (!o_in_ack)
            @(posedge i_clk);
        wait_cycles($urandom_range(6));
        i_in_req  <= 1'b0;
        i_gen_amt <= to_bcd($urandom_range(99));    // data is free once req is low
        @(posedge i_clk);
        while (o_in_ack)
            @(posedge i_clk);
    endtask

    task automatic take_result();
        int          amount;
        fib_result_t expected;
        while (!o_out_req)
            @(posedge i_clk);
        assert (expected_q.size() > 0)
        else stop_with_failure($sformatf("result delivered at %0t with no request outstanding",
            $time));
        amount   = expected_q.pop_front();
        expected = expected_result(amount);
        assert (o_result.digits == expected.digits)
        else stop_with_failure($sformatf(
            "Mismatch at %0t: o_result.digits (amount %0d) expected %h actual %h",
            $time, amount, expected.digits, o_result.digits));
        assert (o_result.overflow == expected.overflow)
        else stop_with_failure($sformatf(
            "Mismatch at %0t: o_result.overflow (amount %0d) expected %b actual %b",
            $time, amount, expected.overflow, o_result.overflow));
        results_checked++;
        wait_cycles($urandom_range(10));    // slow sink
        i_out_ack <= 1'b1;
        @(posedge i_clk);
        while (o_out_req)
            @(posedge i_clk);
        i_out_ack <= 1'b0;
    endtask

    // ##################################################
    // protocol monitor and timeout
    // ##################################################

    always @(posedge i_clk)
    begin
        cycle_count++;
        if (cycle_count > 1 && (i_rst || !seen_req))
        begin
            assert (o_in_ack === 1'b0)
            else stop_with_failure($sformatf("Mismatch at %0t: o_in_ack expected 0 actual %b",
                $time, o_in_ack));
            assert (o_out_req === 1'b0)
            else stop_with_failure($sformatf("Mismatch at %0t: o_out_req expected 0 actual %b",
                $time, o_out_req));
        end
        if (!i_rst && i_in_req)
            seen_req = 1'b1;

        if (!i_rst && cycle_count > 1)
        begin
            if (!prev_in_ack && o_in_ack)
            begin
                assert (prev_in_req)
                else stop_with_failure("o_in_ack rose while i_in_req was low");
                accepted_count++;
            end
            if (prev_in_ack && !o_in_ack)
            begin
                assert (!prev_in_req)
                else stop_with_failure("o_in_ack fell while i_in_req was still high");
            end
            if (prev_out_req && !prev_out_ack)
            begin
                assert (o_out_req)
                else stop_with_failure("o_out_req fell before i_out_ack rose");
                assert (o_result == prev_result)
                else stop_with_failure($sformatf(
                    "Mismatch at %0t: o_result while offered expected %h actual %h",
                    $time, prev_result, o_result));
            end
            if (!prev_out_ack && i_out_ack)
                delivered_count++;
            if (accepted_count - delivered_count > max_in_flight)
                max_in_flight = accepted_count - delivered_count;
            assert (accepted_count - delivered_count <= MAX_IN_FLIGHT)
            else stop_with_failure("more jobs in flight than the three stages can hold");
        end

        prev_in_req  = i_in_req;
        prev_in_ack  = o_in_ack;
        prev_out_req = o_out_req;
        prev_out_ack = i_out_ack;
        prev_result  = o_result;

        if (cycle_count >= TIMEOUT_CYCLES)
            stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d results checked",
                cycle_count, results_checked, N_JOBS));
    end

    // ##################################################
    // main sequence
    // ##################################################

    initial
    begin
        void'($urandom(SEED));
        i_clk           = 1'b0;
        i_rst           = 1'b1;
        i_in_req        = 1'b0;
        i_gen_amt       = '0;
        i_out_ack       = 1'b0;
        results_checked = 0;
        cycle_count     = 0;
        accepted_count  = 0;
        delivered_count = 0;
        max_in_flight   = 0;
        seen_req        = 1'b0;
        prev_in_req     = 1'b0;
        prev_in_ack     = 1'b0;
        prev_out_req    = 1'b0;
        prev_out_ack    = 1'b0;
        prev_result     = '0;

        wait_cycles(RESET_CYCLES);
        i_rst <= 1'b0;

        fork
            forever take_result();
        join_none

        for (int j = 0; j < N_JOBS; j++)
            send_job(pick_amount(j));

        while (results_checked < N_JOBS)
            @(posedge i_clk);
        wait_cycles(DRAIN_CYCLES);  // a duplicate result would show up here

        // the slow sink backs jobs up into every stage
        assert (max_in_flight == MAX_IN_FLIGHT)
        else stop_with_failure($sformatf("the stages never held %0d jobs at once, most was %0d",
            MAX_IN_FLIGHT, max_in_flight));
        $display("jobs %0d, most in flight %0d", results_checked, max_in_flight);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
